// File: hdl/ahb_pkg.sv
package ahb_pkg;

  // Transfer type on htrans
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // Burst kind, odd codes increment, even nonzero codes wrap
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_t;

  // Transfer size, codes above WORD handled as WORD
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_t;

  typedef enum logic {OKAY = 1'b0, ERROR = 1'b1} hresp_t;

  // Slave controller states
  typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_READ} ahb_state_t;

endpackage

// File: hdl/ahb_sram_ctrl.sv
`timescale 1ns/1ps
`include "sram_defs.svh"

module ahb_sram_ctrl import ahb_pkg::*, sram_pkg::*; (
  input  logic      HCLK,
  input  logic      aresetn,
  input  logic      hsel,
  input  logic      hready_in,
  input  htrans_t   htrans,
  input  hburst_t   hburst,
  input  hsize_t    hsize,
  input  mem_addr_t haddr,
  input  logic      hwrite,
  input  mem_word_t hwdata,
  input  mem_addr_t rd_addr,
  output logic      hreadyout,
  output hresp_t    hresp,
  output mem_word_t hrdata,
  output logic      cmd_accept,
  output logic      beat_advance,
  sram_if.ctrl      mem
);

  ahb_state_t state_q;
  ahb_state_t state_d;
  hsize_t     size_q;
  logic       hwrite_q;
  logic       single_q;
  mem_addr_t  addr_q;
  logic       new_read_q;
  logic       xfer_accept;
  mem_addr_t  sel_addr;
  byte_en_t   lane_sel;

  //////////////////////////////////////////////////////////////////////
  // Address phase
  //////////////////////////////////////////////////////////////////////

  // Only NONSEQ starts a new command
  assign cmd_accept = hsel & hready_in & hreadyout & (htrans == NONSEQ);

  // Generator steps on every SEQ beat including the wait state
  assign beat_advance = (htrans == SEQ);

  // Any active beat latches its address for write bursts
  assign xfer_accept = hsel & hready_in & ((htrans == NONSEQ) | (htrans == SEQ));

  always_ff @(posedge HCLK) begin
    if (xfer_accept) begin
      addr_q <= haddr;
    end
  end

  // Command attributes held for the whole burst
  always_ff @(posedge HCLK or negedge aresetn) begin
    if (!aresetn) begin
      size_q   <= WORD;
      hwrite_q <= 1'b0;
      single_q <= 1'b0;
    end else if (cmd_accept) begin
      size_q   <= hsize;
      hwrite_q <= hwrite;
      single_q <= (hburst == SINGLE);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge aresetn) begin
    if (!aresetn) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (cmd_accept) begin
          if (hwrite) state_d = ST_WRITE;
          else state_d = ST_READ;
        end
      end
      ST_WRITE, ST_READ: begin
        // Back to idle on IDLE or on a NONSEQ meant for another slave
        if ((htrans == IDLE) || ((htrans == NONSEQ) && !hsel)) begin
          state_d = ST_IDLE;
        end else if (cmd_accept) begin
          if (hwrite) state_d = ST_WRITE;
          else state_d = ST_READ;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // First read beat waits one cycle for the array
  always_ff @(posedge HCLK or negedge aresetn) begin
    if (!aresetn) begin
      new_read_q <= 1'b0;
    end else begin
      new_read_q <= cmd_accept & ~hwrite;
    end
  end

  assign hreadyout = ~new_read_q;
  assign hresp     = OKAY;
  assign hrdata    = mem.rdata;

  //////////////////////////////////////////////////////////////////////
  // Array access
  //////////////////////////////////////////////////////////////////////

  // Writes use the captured beat address and reads the generator address
  assign sel_addr = hwrite_q ? addr_q : rd_addr;

  assign mem.wen   = (state_q == ST_WRITE);
  // SINGLE reads only touch the array in the wait cycle
  assign mem.ren   = (state_q == ST_READ) & (~single_q | new_read_q);
  assign mem.addr  = sel_addr[`MEM_AWIDTH-1:2];
  assign mem.wdata = hwdata;

  // Lane select from size and low address bits
  always_comb begin
    case (size_q)
      BYTE:    lane_sel = byte_en_t'(1) << sel_addr[1:0];
      HALF:    lane_sel = sel_addr[1] ? 4'b1100 : 4'b0011;
      default: lane_sel = '1;
    endcase
  end

  assign mem.byte_en = mem.wen ? lane_sel : '0;

  // Read wait state never stretches past one cycle
  a_one_wait: assert property (@(posedge HCLK) disable iff (!aresetn)
    !hreadyout |=> hreadyout)
    else $error("hreadyout low for two cycles");

endmodule

// File: hdl/ahb_sram_top.sv
`timescale 1ns/1ps
`include "sram_defs.svh"

module ahb_sram_top import ahb_pkg::*, sram_pkg::*; (
  input  logic                   HCLK,
  input  logic                   aresetn,
  input  logic                   hsel,
  input  logic                   hready_in,
  input  htrans_t                htrans,
  input  hburst_t                hburst,
  input  hsize_t                 hsize,
  input  logic [`AHB_AWIDTH-1:0] haddr,
  input  logic                   hwrite,
  input  mem_word_t              hwdata,
  output logic                   hreadyout,
  output hresp_t                 hresp,
  output mem_word_t              hrdata
);

  logic      cmd_accept;
  logic      beat_advance;
  mem_addr_t rd_addr;

  // Controller to array access
  sram_if mem_bus ();

  ahb_sram_ctrl u_ctrl (
    .HCLK         (HCLK),
    .aresetn      (aresetn),
    .hsel         (hsel),
    .hready_in    (hready_in),
    .htrans       (htrans),
    .hburst       (hburst),
    .hsize        (hsize),
    .haddr        (haddr[`MEM_AWIDTH-1:0]),
    .hwrite       (hwrite),
    .hwdata       (hwdata),
    .rd_addr      (rd_addr),
    .hreadyout    (hreadyout),
    .hresp        (hresp),
    .hrdata       (hrdata),
    .cmd_accept   (cmd_accept),
    .beat_advance (beat_advance),
    .mem          (mem_bus.ctrl)
  );

  // Read address runs one beat ahead of the data phase
  burst_addr_gen u_addr_gen (
    .HCLK         (HCLK),
    .aresetn      (aresetn),
    .cmd_accept   (cmd_accept),
    .beat_advance (beat_advance),
    .haddr        (haddr[`MEM_AWIDTH-1:0]),
    .hburst       (hburst),
    .hsize        (hsize),
    .rd_addr      (rd_addr)
  );

  sram_array u_array (
    .HCLK    (HCLK),
    .aresetn (aresetn),
    .mem     (mem_bus.mem)
  );

endmodule

// File: hdl/burst_addr_gen.sv
`timescale 1ns/1ps
`include "sram_defs.svh"

module burst_addr_gen import ahb_pkg::*, sram_pkg::*; (
  input  logic      HCLK,
  input  logic      aresetn,
  input  logic      cmd_accept,
  input  logic      beat_advance,
  input  mem_addr_t haddr,
  input  hburst_t   hburst,
  input  hsize_t    hsize,
  output mem_addr_t rd_addr
);

  logic [2:0]             incr_q;
  logic [`WRAP_MASK_W-1:0] wrap_mask_q;
  logic                   wrap_en_q;
  logic [1:0]             size_log;
  logic [2:0]             beat_log;
  logic [`WRAP_MASK_W:0]  wrap_span;
  logic [`WRAP_MASK_W:0]  wrap_last;
  mem_addr_t              mask_ext;
  mem_addr_t              addr_step;

  // log2 of bytes per beat
  always_comb begin
    case (hsize)
      BYTE:    size_log = 2'd0;
      HALF:    size_log = 2'd1;
      default: size_log = 2'd2;
    endcase
  end

  // log2 of beats in a wrap, 16 for the rest
  always_comb begin
    case (hburst)
      WRAP4:   beat_log = 3'd2;
      WRAP8:   beat_log = 3'd3;
      default: beat_log = 3'd4;
    endcase
  end

  // Wrap block size in bytes, then its last offset
  assign wrap_span = {{`WRAP_MASK_W{1'b0}}, 1'b1} << (beat_log + size_log);
  assign wrap_last = wrap_span - 1'b1;

  assign mask_ext  = mem_addr_t'(wrap_mask_q);
  assign addr_step = rd_addr + mem_addr_t'(incr_q);

  always_ff @(posedge HCLK or negedge aresetn) begin
    if (!aresetn) begin
      rd_addr     <= '0;
      incr_q      <= 3'd0;
      wrap_mask_q <= '0;
      wrap_en_q   <= 1'b0;
    end else if (cmd_accept) begin
      rd_addr     <= haddr;
      incr_q      <= 3'b001 << size_log;
      wrap_mask_q <= wrap_last[`WRAP_MASK_W-1:0];
      wrap_en_q   <= (hburst == WRAP4) || (hburst == WRAP8) || (hburst == WRAP16);
    end else if (beat_advance) begin
      // Wrap keeps the upper bits, low bits roll within the block
      if (wrap_en_q) begin
        rd_addr <= (rd_addr & ~mask_ext) | (addr_step & mask_ext);
      end else begin
        rd_addr <= addr_step;
      end
    end
  end

  a_wrap_block: assert property (@(posedge HCLK) disable iff (!aresetn)
    (beat_advance && !cmd_accept && wrap_en_q) |=>
      ((rd_addr & ~mask_ext) == ($past(rd_addr) & ~mask_ext)))
    else $error("wrap burst left its aligned block");

endmodule

// File: hdl/sram_array.sv
`timescale 1ns/1ps
`include "sram_defs.svh"

module sram_array import sram_pkg::*; (
  input logic HCLK,
  input logic aresetn,
  sram_if.mem mem
);

  mem_word_t ram [0:`MEM_WORDS-1];

  //////////////////////////////////////////////////////////////////////
  // Byte-lane write
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (mem.wen) begin
      for (int lane = 0; lane < `BYTE_LANES; lane++) begin
        if (mem.byte_en[lane]) begin
          ram[mem.addr][8*lane +: 8] <= mem.wdata[8*lane +: 8];
        end
      end
    end
  end

  // Registered read, one cycle latency
  always_ff @(posedge HCLK or negedge aresetn) begin
    if (!aresetn) begin
      mem.rdata <= '0;
    end else if (mem.ren) begin
      mem.rdata <= ram[mem.addr];
    end
  end

  // Controller state keeps the two strobes apart
  a_no_rw: assert property (@(posedge HCLK) disable iff (!aresetn)
    !(mem.wen && mem.ren))
    else $error("array written and read in the same cycle");

endmodule

// File: hdl/sram_defs.svh
`ifndef SRAM_DEFS_SVH
`define SRAM_DEFS_SVH

// AHB bus widths
`define AHB_DWIDTH 32
`define AHB_AWIDTH 32

// Slave decodes 4 KiB, byte addressed
`define MEM_AWIDTH 12
`define MEM_WORDS 1024
`define BYTE_LANES 4

// Widest wrap boundary, 16 beats of 4 bytes
`define WRAP_MASK_W 6

`endif

// File: hdl/sram_if.sv
`timescale 1ns/1ps

// One access per cycle from the AHB controller to the array
interface sram_if import sram_pkg::*; ();

  logic        wen;
  logic        ren;
  word_index_t addr;
  byte_en_t    byte_en;
  mem_word_t   wdata;
  mem_word_t   rdata;

  // Controller side
  modport ctrl (
    output wen, ren, addr, byte_en, wdata,
    input  rdata
  );

  // Array side
  modport mem (
    input  wen, ren, addr, byte_en, wdata,
    output rdata
  );

endinterface

// File: hdl/sram_pkg.sv
`include "sram_defs.svh"

package sram_pkg;

  // One data word of the array
  typedef logic [`AHB_DWIDTH-1:0] mem_word_t;

  // Byte address inside the slave window
  typedef logic [`MEM_AWIDTH-1:0] mem_addr_t;

  // Word address, byte offset stripped
  typedef logic [`MEM_AWIDTH-3:0] word_index_t;

  // One bit per byte lane
  typedef logic [`BYTE_LANES-1:0] byte_en_t;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the AHB SRAM testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_ahb_sram -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_ahb_sram)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
  exit 0
else
  exit 1
fi

// File: verif/tb_ahb_sram.sv
`timescale 1ns/1ps
`include "sram_defs.svh"

module tb_ahb_sram import ahb_pkg::*, sram_pkg::*;;

  // Twice the summed worst-case test lengths
  localparam int TEST_CYCLES    = 1000;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
  localparam int WAIT_LIMIT     = 8;

  logic                   HCLK;
  logic                   aresetn;
  logic                   hsel;
  logic                   hready_in;
  htrans_t                htrans;
  hburst_t                hburst;
  hsize_t                 hsize;
  logic [`AHB_AWIDTH-1:0] haddr;
  logic                   hwrite;
  mem_word_t              hwdata;
  logic                   hreadyout;
  hresp_t                 hresp;
  mem_word_t              hrdata;

  // Expected array contents
  mem_word_t   shadow [0:`MEM_WORDS-1];
  logic [15:0] lfsr_q = 16'd87;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  tb_clock_gen clk_gen (.HCLK(HCLK), .aresetn(aresetn));

  ahb_sram_top uut (.*);

  always @(posedge HCLK) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks and models
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input mem_word_t got, input mem_word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s gave %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input hresp_t got, input hresp_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s gave %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_ready(input bit got, input bit exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s gave %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Galois LFSR with taps x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One step per data bit
  function automatic mem_word_t rand_word();
    mem_word_t w;
    for (int i = 0; i < `AHB_DWIDTH; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w[i] = lfsr_q[0];
    end
    return w;
  endfunction

  // Lane kept if the size covers it at this address
  function automatic void shadow_write(input mem_addr_t a, input hsize_t s, input mem_word_t d);
    for (int l = 0; l < `BYTE_LANES; l++) begin
      if ((s == BYTE && int'(a[1:0]) == l) || (s == HALF && l[1] == a[1]) ||
          (s != BYTE && s != HALF)) begin
        shadow[a[`MEM_AWIDTH-1:2]][8*l +: 8] = d[8*l +: 8];
      end
    end
  endfunction

  function automatic logic [`AHB_AWIDTH-1:0] bus_addr(input mem_addr_t a);
    return {{(`AHB_AWIDTH-`MEM_AWIDTH){1'b0}}, a};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // AHB master helpers driving on the falling edge
  //////////////////////////////////////////////////////////////////////

  // Counts wait states until hreadyout rises
  task automatic wait_ready(output int waits);
    waits = 0;
    while (!hreadyout && waits < WAIT_LIMIT) begin
      waits++;
      @(negedge HCLK);
    end
    if (!hreadyout) begin
      errors++;
      $display("Slave stayed not ready for %0d cycles", WAIT_LIMIT);
    end
  endtask

  // Returns at the start of the data phase
  task automatic addr_phase(input htrans_t t, input hburst_t b, input hsize_t s,
                            input logic w, input mem_addr_t a);
    int waits;
    htrans = t;
    hburst = b;
    hsize  = s;
    hwrite = w;
    haddr  = bus_addr(a);
    wait_ready(waits);
    @(negedge HCLK);
  endtask

  task automatic write_data(input mem_addr_t a, input hsize_t s, input mem_word_t d);
    addr_phase(NONSEQ, SINGLE, s, 1'b1, a);
    htrans = IDLE;
    hwdata = d;
    shadow_write(a, s, d);
    check_ready(hreadyout, 1'b1, "write data phase ready");
    @(negedge HCLK);
  endtask

  // Word read burst with each beat checked against the shadow
  task automatic read_burst(input mem_addr_t start, input hburst_t b, input int beats);
    mem_addr_t addrs [16];
    int        span;
    int        base;
    int        waits;
    // A wrap burst stays in its block of beats times four bytes
    span = (b == WRAP4 || b == WRAP8 || b == WRAP16) ? 4 * beats : 1 << `MEM_AWIDTH;
    base = int'(start) - int'(start) % span;
    for (int i = 0; i < beats; i++) begin
      addrs[i] = mem_addr_t'(base + (int'(start) - base + 4 * i) % span);
    end
    addr_phase(NONSEQ, b, WORD, 1'b0, start);
    for (int i = 0; i < beats; i++) begin
      // Next address held through the wait state
      if (i + 1 < beats) begin
        htrans = SEQ;
        haddr  = bus_addr(addrs[i + 1]);
      end else begin
        htrans = IDLE;
      end
      wait_ready(waits);
      check_ready(bit'(waits == (i == 0 ? 1 : 0)), 1'b1, "one wait state on first beat only");
      check_resp(hresp, OKAY, "read response");
      check_word(hrdata, shadow[addrs[i][`MEM_AWIDTH-1:2]],
                 $sformatf("read beat %0d at %h", i, addrs[i]));
      @(negedge HCLK);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_values();
    check_ready(hreadyout, 1'b1, "hreadyout after reset");
    check_resp(hresp, OKAY, "hresp after reset");
  endtask

  task automatic test_single_word();
    write_data(12'h010, WORD, rand_word());
    read_burst(12'h010, SINGLE, 1);
  endtask

  // Each narrow write merged into the earlier word
  task automatic test_byte_half();
    write_data(12'h020, WORD, rand_word());
    for (int k = 0; k < 4; k++) begin
      write_data(12'h020 + mem_addr_t'(k), BYTE, rand_word());
      read_burst(12'h020, SINGLE, 1);
    end
    write_data(12'h022, HALF, rand_word());
    read_burst(12'h020, SINGLE, 1);
  endtask

  task automatic test_incr_bursts();
    for (int k = 0; k < 8; k++) begin
      write_data(12'h100 + mem_addr_t'(4 * k), WORD, rand_word());
    end
    read_burst(12'h100, INCR4, 4);
    read_burst(12'h100, INCR8, 8);
  endtask

  // WRAP4 from offset 8 gives words 2, 3, 0, 1
  task automatic test_wrap_bursts();
    for (int k = 0; k < 8; k++) begin
      write_data(12'h200 + mem_addr_t'(4 * k), WORD, rand_word());
    end
    read_burst(12'h208, WRAP4, 4);
    read_burst(12'h218, WRAP8, 8);
  endtask

  // Read address phase overlaps the write data phase
  task automatic test_write_then_read();
    mem_word_t d;
    mem_addr_t a;
    for (int k = 0; k < 2; k++) begin
      d = rand_word();
      a = 12'h300 + mem_addr_t'(4 * k);
      addr_phase(NONSEQ, SINGLE, WORD, 1'b1, a);
      hwdata = d;
      shadow_write(a, WORD, d);
      read_burst(a, SINGLE, 1);
    end
  endtask

  initial begin
    hsel      = 1'b1;
    hready_in = 1'b1;
    htrans    = IDLE;
    hburst    = SINGLE;
    hsize     = WORD;
    haddr     = '0;
    hwrite    = 1'b0;
    hwdata    = '0;
    wait (aresetn);
    @(negedge HCLK);
    test_reset_values();
    test_single_word();
    test_byte_half();
    test_incr_bursts();
    test_wrap_bursts();
    test_write_then_read();
    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic HCLK,
  output logic aresetn
);

  // 10 ns period
  initial begin
    HCLK = 1'b0;
    forever #5 HCLK = ~HCLK;
  end

  // Reset low for 8 clocks, released on a falling edge
  initial begin
    aresetn = 1'b0;
    repeat (8) @(posedge HCLK);
    @(negedge HCLK);
    aresetn = 1'b1;
  end

endmodule

// File: verilog.f
+incdir+hdl
hdl/ahb_pkg.sv
hdl/sram_pkg.sv
hdl/sram_if.sv
hdl/ahb_sram_ctrl.sv
hdl/burst_addr_gen.sv
hdl/sram_array.sv
hdl/ahb_sram_top.sv
verif/tb_clock_gen.sv
verif/tb_ahb_sram.sv
